// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_byte_histogram
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Done: no errors$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: src.f
src/hist_pkg.sv
src/byte_intake.sv
src/hist_bank.sv
src/count_readout.sv
src/byte_histogram.sv
tb/hist_checker.sv
tb/tb_byte_histogram.sv

// File: src/byte_histogram.sv
`timescale 1ns/1ns
`default_nettype none

module byte_histogram (
    input  logic             clk,
    input  logic             rst,
    input  logic             in_valid,
    input  hist_pkg::byte_t  in_byte,
    output logic             in_ready,
    output logic             out_valid,
    output hist_pkg::byte_t  out_bin,
    output hist_pkg::count_t out_count,
    output logic             out_last,
    input  logic             out_ready,
    output hist_pkg::count_t file_total,
    output logic             total_valid
);

    logic [hist_pkg::NUM_BANKS-1:0]                upd_valid;
    hist_pkg::bank_idx_t [hist_pkg::NUM_BANKS-1:0] upd_index;
    logic [hist_pkg::NUM_BANKS-1:0]                upd_ready;
    logic [hist_pkg::NUM_BANKS-1:0]                bank_idle;
    logic [hist_pkg::NUM_BANKS-1:0]                rd_en;
    hist_pkg::bank_idx_t [hist_pkg::NUM_BANKS-1:0] rd_index;
    hist_pkg::count_t [hist_pkg::NUM_BANKS-1:0]    rd_count;
    logic                                          drain_start;
    logic                                          drain_done;

    byte_intake byte_intake_inst (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (in_valid),
        .in_byte     (in_byte),
        .in_ready    (in_ready),
        .upd_valid   (upd_valid),
        .upd_index   (upd_index),
        .upd_ready   (upd_ready),
        .bank_idle   (bank_idle),
        .drain_start (drain_start),
        .drain_done  (drain_done),
        .file_total  (file_total)
    );

    // bank k holds every bin whose low two bits equal k
    for (genvar k = 0; k < hist_pkg::NUM_BANKS; k++) begin : g_bank
        hist_bank hist_bank_inst (
            .clk       (clk),
            .rst       (rst),
            .upd_valid (upd_valid[k]),
            .upd_index (upd_index[k]),
            .upd_ready (upd_ready[k]),
            .idle      (bank_idle[k]),
            .rd_en     (rd_en[k]),
            .rd_index  (rd_index[k]),
            .rd_count  (rd_count[k])
        );
    end

    count_readout count_readout_inst (
        .clk         (clk),
        .rst         (rst),
        .drain_start (drain_start),
        .drain_done  (drain_done),
        .rd_en       (rd_en),
        .rd_index    (rd_index),
        .rd_count    (rd_count),
        .file_total  (file_total),
        .out_valid   (out_valid),
        .out_bin     (out_bin),
        .out_count   (out_count),
        .out_last    (out_last),
        .out_ready   (out_ready),
        .total_valid (total_valid)
    );

endmodule

`default_nettype wire

// File: src/byte_intake.sv
`timescale 1ns/1ns
`default_nettype none

module byte_intake (
    input  logic                                          clk,
    input  logic                                          rst,
    input  logic                                          in_valid,
    input  hist_pkg::byte_t                               in_byte,
    output logic                                          in_ready,
    output logic [hist_pkg::NUM_BANKS-1:0]                upd_valid,
    output hist_pkg::bank_idx_t [hist_pkg::NUM_BANKS-1:0] upd_index,
    input  logic [hist_pkg::NUM_BANKS-1:0]                upd_ready,
    input  logic [hist_pkg::NUM_BANKS-1:0]                bank_idle,
    output logic                                          drain_start,
    input  logic                                          drain_done,
    output hist_pkg::count_t                              file_total
);

    hist_pkg::intake_state_t state;
    hist_pkg::bank_sel_t     sel;
    logic                    accepting;
    logic                    in_xfer;

    assign sel       = in_byte[1:0];                       // low bits pick the bank
    assign accepting = (state == hist_pkg::ACCEPT);
    assign in_ready  = accepting && upd_ready[sel];        // stall while target bank is busy
    assign in_xfer   = in_valid && in_ready;

    // the byte goes straight through to its bank, no buffering here
    always_comb begin
        for (int k = 0; k < hist_pkg::NUM_BANKS; k++) begin
            upd_valid[k] = in_valid && accepting && (sel == hist_pkg::bank_sel_t'(k));
            upd_index[k] = in_byte[7:2];
        end
    end

    // all banks quiet means every update of the file has landed
    assign drain_start = (state == hist_pkg::FLUSH) && (&bank_idle);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= hist_pkg::ACCEPT;
            file_total <= '0;
        end else begin
            case (state)
                hist_pkg::ACCEPT: begin
                    if (in_xfer) begin
                        file_total <= file_total + 1'b1;   // marker counts too
                        if (in_byte == hist_pkg::EOF_BYTE) begin
                            state <= hist_pkg::FLUSH;
                        end
                    end
                end
                hist_pkg::FLUSH: begin
                    if (drain_start) begin
                        state <= hist_pkg::DRAIN;
                    end
                end
                hist_pkg::DRAIN: begin
                    if (drain_done) begin
                        state      <= hist_pkg::ACCEPT;
                        file_total <= '0;                  // next file starts fresh
                    end
                end
                default: state <= hist_pkg::ACCEPT;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: src/count_readout.sv
`timescale 1ns/1ns
`default_nettype none

module count_readout (
    input  logic                                          clk,
    input  logic                                          rst,
    input  logic                                          drain_start,
    output logic                                          drain_done,
    output logic [hist_pkg::NUM_BANKS-1:0]                rd_en,
    output hist_pkg::bank_idx_t [hist_pkg::NUM_BANKS-1:0] rd_index,
    input  hist_pkg::count_t [hist_pkg::NUM_BANKS-1:0]    rd_count,
    input  hist_pkg::count_t                              file_total,
    output logic                                          out_valid,
    output hist_pkg::byte_t                               out_bin,
    output hist_pkg::count_t                              out_count,
    output logic                                          out_last,
    input  logic                                          out_ready,
    output logic                                          total_valid
);

    hist_pkg::readout_state_t state;
    hist_pkg::byte_t          bin;        // bin being drained
    hist_pkg::bank_sel_t      sel;
    logic                     out_xfer;

    assign sel = bin[1:0];

    // one read per bin, to the bank that owns it
    always_comb begin
        for (int k = 0; k < hist_pkg::NUM_BANKS; k++) begin
            rd_en[k]    = (state == hist_pkg::RD_FETCH) && (sel == hist_pkg::bank_sel_t'(k));
            rd_index[k] = bin[7:2];
        end
    end

    // bank data stays put until the next rd_en, so a stall keeps it stable
    assign out_valid = (state == hist_pkg::RD_PRESENT);
    assign out_bin   = bin;
    assign out_count = rd_count[sel];
    assign out_last  = out_valid && (bin == hist_pkg::LAST_BIN);
    assign out_xfer  = out_valid && out_ready;

    assign drain_done  = out_xfer && out_last;
    assign total_valid = drain_done;          // total goes out with the last bin

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= hist_pkg::RD_IDLE;
            bin   <= '0;
        end else begin
            case (state)
                hist_pkg::RD_IDLE: begin
                    if (drain_start) begin
                        state <= hist_pkg::RD_FETCH;
                        bin   <= '0;
                    end
                end
                hist_pkg::RD_FETCH: state <= hist_pkg::RD_PRESENT;
                hist_pkg::RD_PRESENT: begin
                    if (out_xfer) begin
                        if (out_last) begin
                            state <= hist_pkg::RD_IDLE;
                            bin   <= '0;
                        end else begin
                            state <= hist_pkg::RD_FETCH;
                            bin   <= bin + 1'b1;
                        end
                    end
                end
                default: state <= hist_pkg::RD_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: src/hist_bank.sv
`timescale 1ns/1ns
`default_nettype none

module hist_bank (
    input  logic                clk,
    input  logic                rst,
    input  logic                upd_valid,
    input  hist_pkg::bank_idx_t upd_index,
    output logic                upd_ready,
    output logic                idle,
    input  logic                rd_en,
    input  hist_pkg::bank_idx_t rd_index,
    output hist_pkg::count_t    rd_count
);

    hist_pkg::count_t        mem [hist_pkg::BANK_DEPTH];
    hist_pkg::bank_state_t   state;
    hist_pkg::bank_idx_t     idx_q;     // entry being updated
    hist_pkg::count_t        cnt_q;     // value fetched in READ
    logic                    upd_xfer;

    assign upd_ready = (state == hist_pkg::BANK_IDLE);
    assign idle      = (state == hist_pkg::BANK_IDLE);
    assign upd_xfer  = upd_valid && upd_ready;

    // update FSM: IDLE -> READ -> WRITE -> IDLE
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= hist_pkg::BANK_IDLE;
        end else begin
            case (state)
                hist_pkg::BANK_IDLE: begin
                    if (upd_xfer) begin
                        state <= hist_pkg::BANK_READ;
                    end
                end
                hist_pkg::BANK_READ:  state <= hist_pkg::BANK_WRITE;
                hist_pkg::BANK_WRITE: state <= hist_pkg::BANK_IDLE;
                default:              state <= hist_pkg::BANK_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (upd_xfer) begin
            idx_q <= upd_index;
        end
        if (state == hist_pkg::BANK_READ) begin
            cnt_q <= mem[idx_q];
        end
    end

    // counter array; the drain clears what it reads
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < hist_pkg::BANK_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else begin
            if (state == hist_pkg::BANK_WRITE) begin
                mem[idx_q] <= cnt_q + 1'b1;
            end
            if (rd_en) begin
                mem[rd_index] <= '0;           // read-and-clear
            end
        end
    end

    // registered drain data, valid the cycle after rd_en
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_count <= mem[rd_index];
        end
    end

endmodule

`default_nettype wire

// File: src/hist_pkg.sv
`default_nettype none

package hist_pkg;

    // widths with a meaning of their own
    typedef logic [7:0]  byte_t;      // input byte, doubles as the bin number
    typedef logic [31:0] count_t;     // bin count or file total
    typedef logic [1:0]  bank_sel_t;  // bank number, byte bits 1:0
    typedef logic [5:0]  bank_idx_t;  // entry within a bank, byte bits 7:2

    localparam int     NUM_BANKS  = 4;
    localparam int     BANK_DEPTH = 64;
    localparam byte_t  EOF_BYTE   = 8'h1A;  // end of file, counted like any byte
    localparam byte_t  LAST_BIN   = 8'd255;

    // intake: take bytes, wait for banks to settle, wait for the drain
    typedef enum logic [1:0] {
        ACCEPT,
        FLUSH,
        DRAIN
    } intake_state_t;

    // bank update path, one read-modify-write at a time
    typedef enum logic [1:0] {
        BANK_IDLE,
        BANK_READ,
        BANK_WRITE
    } bank_state_t;

    // readout: issue the read, then hold the count on the output
    typedef enum logic [1:0] {
        RD_IDLE,
        RD_FETCH,
        RD_PRESENT
    } readout_state_t;

endpackage

`default_nettype wire

// File: tb/hist_checker.sv
`timescale 1ns/1ns
`default_nettype none

module hist_checker (
    input  logic             clk,
    input  logic             rst,
    input  logic             in_valid,
    input  hist_pkg::byte_t  in_byte,
    input  logic             in_ready,
    input  logic             out_valid,
    input  hist_pkg::byte_t  out_bin,
    input  hist_pkg::count_t out_count,
    input  logic             out_last,
    input  logic             out_ready,
    input  hist_pkg::count_t file_total,
    input  logic             total_valid,
    input  logic             report,
    output int               errors,
    output int               files_done
);

    hist_pkg::count_t ref_hist [256];   // expected count per bin
    hist_pkg::count_t ref_total;        // input transfers of the current file
    hist_pkg::byte_t  next_bin;
    logic             draining;         // marker seen, last bin not yet out
    logic             stalled;
    hist_pkg::byte_t  held_bin;
    hist_pkg::count_t held_count;
    logic             held_last;
    int               err_count    = 0;
    int               drained      = 0;
    int               bins_checked = 0;

    assign errors     = err_count;
    assign files_done = drained;

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        err_count++;
        $display("Error at %0t ns: %s expected %0d, got %0d", $time, name, expected, actual);
    endtask

    task automatic report_failure(input string what);
        err_count++;
        $display("Failure at %0t ns: %s", $time, what);
    endtask

    // sampled mid-cycle, where both handshakes are settled
    always @(negedge clk) begin
        if (rst) begin
            for (int b = 0; b < 256; b++) begin
                ref_hist[b] = '0;
            end
            ref_total = '0;
            next_bin  = '0;
            draining  = 1'b0;
            stalled   = 1'b0;
        end else begin
            if (draining && in_valid && in_ready) begin
                report_failure("input byte accepted while the file was still draining");
            end else if (draining && in_ready) begin
                report_failure("in_ready went high before the last bin was sent");
            end else if (in_valid && in_ready) begin
                ref_hist[in_byte] = ref_hist[in_byte] + 1;
                ref_total = ref_total + 1;
                if (in_byte == hist_pkg::EOF_BYTE) draining = 1'b1;
            end
            if (stalled) begin                  // output must hold under back-pressure
                if (!out_valid) report_failure("out_valid dropped before its transfer");
                if (out_bin != held_bin) report_mismatch("out_bin", 32'(held_bin), 32'(out_bin));
                if (out_count != held_count) report_mismatch("out_count", held_count, out_count);
                if (out_last != held_last) report_mismatch("out_last", 32'(held_last),
                                                           32'(out_last));
            end
            if (total_valid && !(out_valid && out_ready && out_last)) begin
                report_failure("total_valid pulsed outside the last bin transfer");
            end
            if (out_valid && out_ready) begin
                if (out_bin != next_bin) report_mismatch("out_bin", 32'(next_bin), 32'(out_bin));
                if (out_count != ref_hist[next_bin]) begin
                    report_mismatch("out_count", ref_hist[next_bin], out_count);
                end
                if (out_last != (next_bin == hist_pkg::LAST_BIN)) begin
                    report_mismatch("out_last", 32'(next_bin == hist_pkg::LAST_BIN), 32'(out_last));
                end
                ref_hist[next_bin] = '0;        // reading a bin clears it
                bins_checked++;
                if (next_bin == hist_pkg::LAST_BIN) begin
                    if (!total_valid) report_failure("total_valid missing on the last bin");
                    else if (file_total != ref_total) begin
                        report_mismatch("file_total", ref_total, file_total);
                    end
                    ref_total = '0;
                    draining  = 1'b0;
                    drained++;
                end
                next_bin = next_bin + 8'd1;
            end
            stalled    = out_valid && !out_ready;
            held_bin   = out_bin;
            held_count = out_count;
            held_last  = out_last;
        end
    end

    always @(posedge report) begin
        $display("Checker: %0d bins checked over %0d files, %0d errors",
                 bins_checked, drained, err_count);
    end

endmodule

`default_nettype wire

// File: tb/tb_byte_histogram.sv
`timescale 1ns/1ns
`default_nettype none

module tb_byte_histogram;

    localparam int CLK_PERIOD     = 8;
    localparam int NUM_ENTRIES    = 18;
    localparam int NUM_FILES      = 2;
    localparam int TIMEOUT_CYCLES = NUM_ENTRIES * 8 + 2 * 600 + 500;

    // entry is {idle cycles before the byte, byte}; both files end in the marker
    localparam logic [11:0] STIM [NUM_ENTRIES] = '{
        {4'd0, 8'h00}, {4'd0, 8'h01}, {4'd0, 8'h02}, {4'd0, 8'h03},     // all four banks
        {4'd0, 8'h41}, {4'd0, 8'h41}, {4'd0, 8'h41}, {4'd0, 8'h41},     // same bank back to back
        {4'd0, 8'h41}, {4'd2, 8'h42}, {4'd1, 8'hFF}, {4'd0, 8'h1A},
        {4'd0, 8'h41}, {4'd0, 8'h41}, {4'd3, 8'h7E}, {4'd0, 8'h80},     // second file
        {4'd1, 8'hFC}, {4'd0, 8'h1A}
    };

    logic             clk;
    logic             rst;
    logic             in_valid;
    hist_pkg::byte_t  in_byte;
    logic             in_ready;
    logic             out_valid;
    hist_pkg::byte_t  out_bin;
    hist_pkg::count_t out_count;
    logic             out_last;
    logic             out_ready;
    hist_pkg::count_t file_total;
    logic             total_valid;
    logic             report;
    int               errors;
    int               files_done;
    int               cycle_count;
    integer           seed = 94938;

    byte_histogram byte_histogram_inst (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (in_valid),
        .in_byte     (in_byte),
        .in_ready    (in_ready),
        .out_valid   (out_valid),
        .out_bin     (out_bin),
        .out_count   (out_count),
        .out_last    (out_last),
        .out_ready   (out_ready),
        .file_total  (file_total),
        .total_valid (total_valid)
    );

    hist_checker hist_checker_inst (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (in_valid),
        .in_byte     (in_byte),
        .in_ready    (in_ready),
        .out_valid   (out_valid),
        .out_bin     (out_bin),
        .out_count   (out_count),
        .out_last    (out_last),
        .out_ready   (out_ready),
        .file_total  (file_total),
        .total_valid (total_valid),
        .report      (report),
        .errors      (errors),
        .files_done  (files_done)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        out_ready = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            out_ready = ($random(seed) & 7) != 0;  // ready about 7 cycles in 8
        end
    end

    initial begin
        logic accepted;
        rst      = 1'b1;
        in_valid = 1'b0;
        in_byte  = '0;
        report   = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            in_valid = 1'b0;
            repeat (STIM[i][11:8]) begin
                @(posedge clk);
                #1;
            end
            in_valid = 1'b1;
            in_byte  = STIM[i][7:0];
            accepted = 1'b0;
            while (!accepted) begin
                @(negedge clk);
                accepted = in_ready;                // transfer lands on the next edge
                @(posedge clk);
                #1;
            end
        end
        in_valid = 1'b0;
        wait (files_done == NUM_FILES);
        repeat (4) @(posedge clk);
        report = 1'b1;
        #1;
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        report = 1'b1;
        #1;
        $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire
